//--- include/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// ##################################################
// datapath sizes
// ##################################################
`define PIPE_XLEN 32
`define PIPE_REG_W 5

// jal links into this register
`define PIPE_RA_REG 31

// use time of an operand that is never read
`define PIPE_T_INF 7

`endif

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// low bit of each instruction field
	localparam int unsigned op_lsb = 26;
	localparam int unsigned rs_lsb = 21;
	localparam int unsigned rt_lsb = 16;
	localparam int unsigned rd_lsb = 11;
	localparam int unsigned shamt_lsb = 6;
	localparam int unsigned funct_lsb = 0;

	// op and funct are six bits wide, the register and shift fields five
	localparam int unsigned opcode_w = 6;
	localparam int unsigned field_w = 5;

	// ##################################################
	// opcode and funct values of the supported subset
	// ##################################################
	localparam logic [opcode_w-1:0] op_special = 6'h00;
	localparam logic [opcode_w-1:0] op_j = 6'h02;
	localparam logic [opcode_w-1:0] op_jal = 6'h03;
	localparam logic [opcode_w-1:0] op_beq = 6'h04;
	localparam logic [opcode_w-1:0] op_ori = 6'h0d;
	localparam logic [opcode_w-1:0] op_lui = 6'h0f;
	localparam logic [opcode_w-1:0] op_lw = 6'h23;
	localparam logic [opcode_w-1:0] op_sw = 6'h2b;

	localparam logic [opcode_w-1:0] fn_jr = 6'h08;
	localparam logic [opcode_w-1:0] fn_movz = 6'h0a;
	localparam logic [opcode_w-1:0] fn_addu = 6'h21;
	localparam logic [opcode_w-1:0] fn_subu = 6'h23;

	typedef enum logic [3:0] {
		kind_addu,
		kind_subu,
		kind_lui,
		kind_ori,
		kind_lw,
		kind_sw,
		kind_beq,
		kind_j,
		kind_jal,
		kind_jr,
		kind_movz,
		kind_nop,
		kind_unknown
	} instr_kind_t;

	// datapath class, which is what most control decisions look at
	typedef enum logic [3:0] {
		class_cal_r,
		class_cal_i,
		class_load,
		class_store,
		class_branch,
		class_jump_i,
		class_jump_r,
		class_cmov,
		class_nop,
		class_unknown
	} dp_class_t;

endpackage

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

`include "pipe_config.svh"

package ctrl_pkg;

	typedef enum logic [1:0] {
		npc_disabled,
		npc_jump_when_equal,
		npc_jump_index,
		npc_jump_reg
	} npc_mode_t;

	typedef enum logic [1:0] {
		ext_signed,
		ext_unsigned,
		ext_pad_upper
	} ext_mode_t;

	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_or,
		alu_movz
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_none,
		wb_alu,
		wb_mem,
		wb_link
	} wb_sel_t;

	// ##################################################
	// forwarding selects, named source stage to sink stage
	// ##################################################
	typedef enum logic [3:0] {
		fwd_orig,
		fwd_e2d_link,
		fwd_e2d_cmov,
		fwd_m2d_alu,
		fwd_m2d_link,
		fwd_w2d_rf,
		fwd_m2e_alu,
		fwd_m2e_link,
		fwd_w2e_rf,
		fwd_w2m_rf
	} fwd_sel_t;

	// two source registers and one destination, zero when unused
	typedef struct packed {
		logic [`PIPE_REG_W-1:0] reg1;
		logic [`PIPE_REG_W-1:0] reg2;
		logic [`PIPE_REG_W-1:0] regw;
	} reg_tuple_t;

	// register 0 never carries a dependency
	function automatic logic reg_hit(
		input logic [`PIPE_REG_W-1:0] src,
		input logic [`PIPE_REG_W-1:0] dst
	);
		return (src == dst) && (src != '0);
	endfunction

endpackage

`default_nettype wire

//--- hdl/instr_classify.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module instr_classify import isa_pkg::*; (
	input  wire [`PIPE_XLEN-1:0] instr,
	output instr_kind_t          kind,
	output dp_class_t            dp_class
);

	logic [opcode_w-1:0] op;
	logic [opcode_w-1:0] funct;
	logic [field_w-1:0]  rs;
	logic [field_w-1:0]  rt;
	logic [field_w-1:0]  rd;
	logic [field_w-1:0]  shamt;
	logic                special;

	assign op = instr[op_lsb +: opcode_w];
	assign funct = instr[funct_lsb +: opcode_w];
	assign rs = instr[rs_lsb +: field_w];
	assign rt = instr[rt_lsb +: field_w];
	assign rd = instr[rd_lsb +: field_w];
	assign shamt = instr[shamt_lsb +: field_w];
	assign special = (op == op_special);

	// the all-zero word goes first since it would otherwise look like sll
	always_comb begin
		if (instr == '0) begin
			kind = kind_nop;
		end else if (special && funct == fn_addu && shamt == '0) begin
			kind = kind_addu;
		end else if (special && funct == fn_subu && shamt == '0) begin
			kind = kind_subu;
		end else if (special && funct == fn_jr && rt == '0 && rd == '0 && shamt == '0) begin
			kind = kind_jr;
		end else if (special && funct == fn_movz && shamt == '0) begin
			kind = kind_movz;
		end else if (op == op_lui && rs == '0) begin
			kind = kind_lui;
		end else if (op == op_ori) begin
			kind = kind_ori;
		end else if (op == op_lw) begin
			kind = kind_lw;
		end else if (op == op_sw) begin
			kind = kind_sw;
		end else if (op == op_beq) begin
			kind = kind_beq;
		end else if (op == op_j) begin
			kind = kind_j;
		end else if (op == op_jal) begin
			kind = kind_jal;
		end else begin
			kind = kind_unknown;
		end
	end

	always_comb begin
		case (kind)
			kind_addu, kind_subu: dp_class = class_cal_r;
			kind_lui, kind_ori:   dp_class = class_cal_i;
			kind_lw:              dp_class = class_load;
			kind_sw:              dp_class = class_store;
			kind_beq:             dp_class = class_branch;
			kind_j, kind_jal:     dp_class = class_jump_i;
			kind_jr:              dp_class = class_jump_r;
			kind_movz:            dp_class = class_cmov;
			kind_nop:             dp_class = class_nop;
			default:              dp_class = class_unknown;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/stage_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module stage_pipe #(
	parameter type payload_t = logic [`PIPE_XLEN-1:0]
) (
	input  wire      clk,
	input  wire      rst_n,
	input  wire      stall,
	input  payload_t d_payload,
	output payload_t e_payload,
	output payload_t m_payload,
	output payload_t w_payload
);

	// ##################################################
	// E, M and W stage registers
	// ##################################################

	// a stall holds D outside, so E takes a bubble while M and W drain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_payload <= '0;
			m_payload <= '0;
			w_payload <= '0;
		end else begin
			e_payload <= stall ? payload_t'('0) : d_payload;
			m_payload <= e_payload;
			w_payload <= m_payload;
		end
	end

	// every stalled cycle has to show up as exactly one bubble in E
	bubble_after_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		stall |=> (e_payload == payload_t'('0))
	);

endmodule

`default_nettype wire

//--- hdl/decode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module decode_ctrl import isa_pkg::*, ctrl_pkg::*; (
	input  wire [`PIPE_XLEN-1:0] d_instr,
	input  wire [`PIPE_XLEN-1:0] rf_read_data2,
	input  wire instr_kind_t     d_kind,
	input  wire instr_kind_t     e_kind,
	input  wire instr_kind_t     m_kind,
	input  wire instr_kind_t     w_kind,
	input  wire dp_class_t       d_class,
	input  wire dp_class_t       e_class,
	input  wire dp_class_t       m_class,
	input  wire dp_class_t       w_class,
	output reg_tuple_t           d_regs,
	output npc_mode_t            npc_mode,
	output ext_mode_t            ext_mode,
	output logic                 alu_src,
	output alu_op_t              alu_op,
	output logic                 dm_write_enable,
	output logic                 rf_write_enable,
	output wb_sel_t              wb_sel
);

	localparam logic [`PIPE_REG_W-1:0] ra_reg = `PIPE_RA_REG;

	logic [`PIPE_REG_W-1:0] rs;
	logic [`PIPE_REG_W-1:0] rt;
	logic [`PIPE_REG_W-1:0] rd;

	assign rs = d_instr[rs_lsb +: `PIPE_REG_W];
	assign rt = d_instr[rt_lsb +: `PIPE_REG_W];
	assign rd = d_instr[rd_lsb +: `PIPE_REG_W];

	// ##################################################
	// register identification in D
	// ##################################################
	always_comb begin
		d_regs = '0;
		if (d_class inside {class_cal_r, class_cal_i, class_load, class_store,
				class_branch, class_jump_r, class_cmov}) begin
			d_regs.reg1 = rs;
		end
		if (d_class inside {class_cal_r, class_store, class_branch, class_cmov}) begin
			d_regs.reg2 = rt;
		end
		case (d_class)
			class_cal_r:              d_regs.regw = rd;
			class_cal_i, class_load:  d_regs.regw = rt;
			class_jump_i:             d_regs.regw = (d_kind == kind_jal) ? ra_reg : '0;
			// a movz that does not move still flows down, aimed at register 0
			class_cmov:               d_regs.regw = (rf_read_data2 == '0) ? rd : '0;
			default:                  d_regs.regw = '0;
		endcase
	end

	// next pc and extender are set up while the instruction sits in D
	always_comb begin
		case (d_kind)
			kind_beq:         npc_mode = npc_jump_when_equal;
			kind_j, kind_jal: npc_mode = npc_jump_index;
			kind_jr:          npc_mode = npc_jump_reg;
			default:          npc_mode = npc_disabled;
		endcase
	end

	always_comb begin
		case (d_kind)
			kind_lui: ext_mode = ext_pad_upper;
			kind_ori: ext_mode = ext_unsigned;
			default:  ext_mode = ext_signed;
		endcase
	end

	// ##################################################
	// E, M and W controls
	// ##################################################
	assign alu_src = (e_class inside {class_cal_i, class_load, class_store});

	// lui reaches the ALU as zero or the padded immediate
	always_comb begin
		case (e_kind)
			kind_addu:       alu_op = alu_add;
			kind_subu:       alu_op = alu_sub;
			kind_movz:       alu_op = alu_movz;
			kind_lw, kind_sw: alu_op = alu_add;
			default:         alu_op = alu_or;
		endcase
	end

	assign dm_write_enable = (m_class == class_store) && (m_kind == kind_sw);

	assign rf_write_enable = (w_class inside {class_cal_r, class_cal_i, class_load, class_cmov})
		|| (w_kind == kind_jal);

	always_comb begin
		if (w_class inside {class_cal_r, class_cal_i, class_cmov}) begin
			wb_sel = wb_alu;
		end else if (w_class == class_load) begin
			wb_sel = wb_mem;
		end else if (w_kind == kind_jal) begin
			wb_sel = wb_link;
		end else begin
			wb_sel = wb_none;
		end
	end

endmodule

`default_nettype wire

//--- hdl/forward_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module forward_select import isa_pkg::*, ctrl_pkg::*; (
	input  wire reg_tuple_t d_regs,
	input  wire reg_tuple_t e_regs,
	input  wire reg_tuple_t m_regs,
	input  wire reg_tuple_t w_regs,
	input  wire dp_class_t  e_class,
	input  wire dp_class_t  m_class,
	input  wire dp_class_t  w_class,
	output fwd_sel_t        fwd_d1,
	output fwd_sel_t        fwd_d2,
	output fwd_sel_t        fwd_e1,
	output fwd_sel_t        fwd_e2,
	output fwd_sel_t        fwd_m
);

	// nearest stage wins, and only if its result already exists there
	function automatic fwd_sel_t sel_d(input logic [`PIPE_REG_W-1:0] src);
		fwd_sel_t sel;
		sel = fwd_orig;
		if (reg_hit(src, e_regs.regw) && e_class == class_jump_i) begin
			sel = fwd_e2d_link;
		end else if (reg_hit(src, e_regs.regw) && e_class == class_cmov) begin
			sel = fwd_e2d_cmov;
		end else if (reg_hit(src, m_regs.regw) && m_class == class_jump_i) begin
			sel = fwd_m2d_link;
		end else if (reg_hit(src, m_regs.regw)
				&& m_class inside {class_cal_r, class_cal_i, class_cmov}) begin
			sel = fwd_m2d_alu;
		end else if (reg_hit(src, w_regs.regw) && w_class != class_nop) begin
			sel = fwd_w2d_rf;
		end
		return sel;
	endfunction

	function automatic fwd_sel_t sel_e(input logic [`PIPE_REG_W-1:0] src);
		fwd_sel_t sel;
		sel = fwd_orig;
		if (reg_hit(src, m_regs.regw) && m_class == class_jump_i) begin
			sel = fwd_m2e_link;
		end else if (reg_hit(src, m_regs.regw)
				&& m_class inside {class_cal_r, class_cal_i, class_cmov}) begin
			sel = fwd_m2e_alu;
		end else if (reg_hit(src, w_regs.regw) && w_class != class_nop) begin
			sel = fwd_w2e_rf;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_d1 = sel_d(d_regs.reg1);
		fwd_d2 = sel_d(d_regs.reg2);
		fwd_e1 = sel_e(e_regs.reg1);
		fwd_e2 = sel_e(e_regs.reg2);
		// store data in M can still pick up the W result
		fwd_m = reg_hit(m_regs.reg2, w_regs.regw) ? fwd_w2m_rf : fwd_orig;
	end

	// register 0 reads as zero, whatever an older instruction aimed at it
	always_comb begin
		zero_reg_not_forwarded: assert final (
			(d_regs.reg1 != '0 || fwd_d1 == fwd_orig)
			&& (d_regs.reg2 != '0 || fwd_d2 == fwd_orig)
			&& (e_regs.reg1 != '0 || fwd_e1 == fwd_orig)
			&& (e_regs.reg2 != '0 || fwd_e2 == fwd_orig)
			&& (m_regs.reg2 != '0 || fwd_m == fwd_orig)
		);
	end

endmodule

`default_nettype wire

//--- hdl/hazard_detect.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module hazard_detect import isa_pkg::*, ctrl_pkg::*; (
	input  wire reg_tuple_t d_regs,
	input  wire reg_tuple_t e_regs,
	input  wire reg_tuple_t m_regs,
	input  wire dp_class_t  d_class,
	input  wire dp_class_t  e_class,
	input  wire dp_class_t  m_class,
	output logic            stall
);

	localparam int unsigned t_w = $clog2(`PIPE_T_INF + 1);
	localparam logic [t_w-1:0] t_inf = `PIPE_T_INF;

	// cycles until D needs an operand, and until E or M can deliver one
	logic [t_w-1:0] use1;
	logic [t_w-1:0] use2;
	logic [t_w-1:0] new_e;
	logic [t_w-1:0] new_m;

	// ##################################################
	// use time of the D operands
	// ##################################################
	always_comb begin
		if (d_class inside {class_branch, class_jump_r, class_cmov}) begin
			use1 = '0;
		end else if (d_class inside {class_cal_r, class_cal_i, class_load, class_store}) begin
			use1 = t_w'(1);
		end else begin
			use1 = t_inf;
		end
	end

	always_comb begin
		if (d_class inside {class_branch, class_cmov}) begin
			use2 = '0;
		end else if (d_class == class_cal_r) begin
			use2 = t_w'(1);
		end else if (d_class == class_store) begin
			use2 = t_w'(2);
		end else begin
			use2 = t_inf;
		end
	end

	// ##################################################
	// new time of the E and M results
	// ##################################################
	always_comb begin
		case (e_class)
			class_load:               new_e = t_w'(2);
			class_cal_r, class_cal_i: new_e = t_w'(1);
			default:                  new_e = '0;
		endcase
	end

	assign new_m = (m_class == class_load) ? t_w'(1) : '0;

	assign stall = (reg_hit(d_regs.reg1, e_regs.regw) && new_e > use1)
		|| (reg_hit(d_regs.reg1, m_regs.regw) && new_m > use1)
		|| (reg_hit(d_regs.reg2, e_regs.regw) && new_e > use2)
		|| (reg_hit(d_regs.reg2, m_regs.regw) && new_m > use2);

	// a nop in D has nothing to wait for
	always_comb begin
		no_stall_on_nop: assert final (!(stall && d_class == class_nop));
	end

endmodule

`default_nettype wire

//--- hdl/pipe_control_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module pipe_control_top import isa_pkg::*, ctrl_pkg::*; (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire [`PIPE_XLEN-1:0]   d_instr,
	input  wire [`PIPE_XLEN-1:0]   rf_read_data2,
	output logic                   stall,
	output npc_mode_t              npc_mode,
	output ext_mode_t              ext_mode,
	output logic [`PIPE_REG_W-1:0] rf_read_addr1,
	output logic [`PIPE_REG_W-1:0] rf_read_addr2,
	output logic                   alu_src,
	output alu_op_t                alu_op,
	output logic                   dm_write_enable,
	output logic                   rf_write_enable,
	output wb_sel_t                wb_sel,
	output logic [`PIPE_REG_W-1:0] rf_write_addr,
	output fwd_sel_t               fwd_d1,
	output fwd_sel_t               fwd_d2,
	output fwd_sel_t               fwd_e1,
	output fwd_sel_t               fwd_e2,
	output fwd_sel_t               fwd_m
);

	logic [`PIPE_XLEN-1:0] e_instr;
	logic [`PIPE_XLEN-1:0] m_instr;
	logic [`PIPE_XLEN-1:0] w_instr;

	instr_kind_t d_kind;
	instr_kind_t e_kind;
	instr_kind_t m_kind;
	instr_kind_t w_kind;
	dp_class_t   d_class;
	dp_class_t   e_class;
	dp_class_t   m_class;
	dp_class_t   w_class;

	reg_tuple_t d_regs;
	reg_tuple_t e_regs;
	reg_tuple_t m_regs;
	reg_tuple_t w_regs;

	// ##################################################
	// stage registers and per-stage classification
	// ##################################################
	stage_pipe #(.payload_t(logic [`PIPE_XLEN-1:0])) u_instr_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.d_payload(d_instr),
		.e_payload(e_instr),
		.m_payload(m_instr),
		.w_payload(w_instr)
	);

	stage_pipe #(.payload_t(reg_tuple_t)) u_regs_pipe (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.d_payload(d_regs),
		.e_payload(e_regs),
		.m_payload(m_regs),
		.w_payload(w_regs)
	);

	instr_classify u_d_classify (.instr(d_instr), .kind(d_kind), .dp_class(d_class));
	instr_classify u_e_classify (.instr(e_instr), .kind(e_kind), .dp_class(e_class));
	instr_classify u_m_classify (.instr(m_instr), .kind(m_kind), .dp_class(m_class));
	instr_classify u_w_classify (.instr(w_instr), .kind(w_kind), .dp_class(w_class));

	// ##################################################
	// control, forwarding and stall
	// ##################################################
	decode_ctrl u_decode_ctrl (
		.d_instr(d_instr),
		.rf_read_data2(rf_read_data2),
		.d_kind(d_kind),
		.e_kind(e_kind),
		.m_kind(m_kind),
		.w_kind(w_kind),
		.d_class(d_class),
		.e_class(e_class),
		.m_class(m_class),
		.w_class(w_class),
		.d_regs(d_regs),
		.npc_mode(npc_mode),
		.ext_mode(ext_mode),
		.alu_src(alu_src),
		.alu_op(alu_op),
		.dm_write_enable(dm_write_enable),
		.rf_write_enable(rf_write_enable),
		.wb_sel(wb_sel)
	);

	forward_select u_forward_select (
		.d_regs(d_regs),
		.e_regs(e_regs),
		.m_regs(m_regs),
		.w_regs(w_regs),
		.e_class(e_class),
		.m_class(m_class),
		.w_class(w_class),
		.fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1),
		.fwd_e2(fwd_e2),
		.fwd_m(fwd_m)
	);

	hazard_detect u_hazard_detect (
		.d_regs(d_regs),
		.e_regs(e_regs),
		.m_regs(m_regs),
		.d_class(d_class),
		.e_class(e_class),
		.m_class(m_class),
		.stall(stall)
	);

	// register file addresses come straight from the D and W tuples
	assign rf_read_addr1 = d_regs.reg1;
	assign rf_read_addr2 = d_regs.reg2;
	assign rf_write_addr = w_regs.regw;

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int period = 20,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset lets go just after a rising edge so the first loaded edge is a clean one
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/pipe_control_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pipe_config.svh"

module pipe_control_tb import isa_pkg::*, ctrl_pkg::*; ();

	localparam int clk_period = 20;
	localparam int drive_delay = 1;
	localparam int check_lead = 2;
	localparam int n_fields = 10;
	localparam string stim_path = "verif/pipe_control_stimulus.txt";

	wire clk;
	wire rst_n;

	logic [`PIPE_XLEN-1:0]  d_instr;
	logic [`PIPE_XLEN-1:0]  rf_read_data2;
	logic                   stall;
	npc_mode_t              npc_mode;
	ext_mode_t              ext_mode;
	logic [`PIPE_REG_W-1:0] rf_read_addr1;
	logic [`PIPE_REG_W-1:0] rf_read_addr2;
	logic                   alu_src;
	alu_op_t                alu_op;
	logic                   dm_write_enable;
	logic                   rf_write_enable;
	wb_sel_t                wb_sel;
	logic [`PIPE_REG_W-1:0] rf_write_addr;
	fwd_sel_t               fwd_d1;
	fwd_sel_t               fwd_d2;
	fwd_sel_t               fwd_e1;
	fwd_sel_t               fwd_e2;
	fwd_sel_t               fwd_m;

	// one entry per stimulus row, expected values are flattened n_fields per row
	logic [`PIPE_XLEN-1:0] stim_instr[$];
	logic [`PIPE_XLEN-1:0] stim_data2[$];
	int expected[$];

	// the word that the E stage holds in the row being checked
	logic [`PIPE_XLEN-1:0] e_word;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	tb_clock_gen #(.period(clk_period), .reset_cycles(4)) u_clock_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	pipe_control_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.d_instr(d_instr),
		.rf_read_data2(rf_read_data2),
		.stall(stall),
		.npc_mode(npc_mode),
		.ext_mode(ext_mode),
		.rf_read_addr1(rf_read_addr1),
		.rf_read_addr2(rf_read_addr2),
		.alu_src(alu_src),
		.alu_op(alu_op),
		.dm_write_enable(dm_write_enable),
		.rf_write_enable(rf_write_enable),
		.wb_sel(wb_sel),
		.rf_write_addr(rf_write_addr),
		.fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1),
		.fwd_e2(fwd_e2),
		.fwd_m(fwd_m)
	);

	// ##################################################
	// stimulus file
	// ##################################################

	// comment and blank lines match no field and are skipped
	task automatic load_stimulus();
		int fd;
		int code;
		int matched;
		int row_line;
		string line;
		logic [`PIPE_XLEN-1:0] instr;
		logic [`PIPE_XLEN-1:0] data2;
		int f [n_fields];
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", stim_path);
			other_errors = other_errors + 1;
			return;
		end
		row_line = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			row_line = row_line + 1;
			if (code != 0) begin
				matched = $sscanf(line, "%h %h %d %d %d %d %d %d %d %d %d %d", instr, data2,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
				if (matched == n_fields + 2) begin
					stim_instr.push_back(instr);
					stim_data2.push_back(data2);
					for (int k = 0; k < n_fields; k++) begin
						expected.push_back(f[k]);
					end
				end else if (matched > 0) begin
					$display("stimulus line %0d has only %0d fields", row_line, matched);
					other_errors = other_errors + 1;
				end
			end
		end
		$fclose(fd);
		if (stim_instr.size() == 0) begin
			$display("the stimulus file holds no usable rows");
			other_errors = other_errors + 1;
		end
	endtask

	// ##################################################
	// checking
	// ##################################################
	function automatic string field_name(input int k);
		case (k)
			0: return "stall";
			1: return "fwd_d1";
			2: return "fwd_d2";
			3: return "fwd_e1";
			4: return "dm_write_enable";
			5: return "rf_write_enable";
			6: return "rf_write_addr";
			7: return "wb_sel";
			8: return "npc_mode";
			default: return "ext_mode";
		endcase
	endfunction

	function automatic int observed(input int k);
		case (k)
			0: return 32'(stall);
			1: return 32'(fwd_d1);
			2: return 32'(fwd_d2);
			3: return 32'(fwd_e1);
			4: return 32'(dm_write_enable);
			5: return 32'(rf_write_enable);
			6: return 32'(rf_write_addr);
			7: return 32'(wb_sel);
			8: return 32'(npc_mode);
			default: return 32'(ext_mode);
		endcase
	endfunction

	// rs is read by everything except nop, j and jal
	function automatic int read_addr1(input logic [`PIPE_XLEN-1:0] w);
		logic [opcode_w-1:0] op;
		op = w[op_lsb +: opcode_w];
		if (w == '0 || op == op_j || op == op_jal) begin
			return 0;
		end
		return int'(w[rs_lsb +: field_w]);
	endfunction

	// rt is read by the R-type ALU ops, movz, sw and beq
	function automatic int read_addr2(input logic [`PIPE_XLEN-1:0] w);
		logic [opcode_w-1:0] op;
		logic [opcode_w-1:0] fn;
		op = w[op_lsb +: opcode_w];
		fn = w[funct_lsb +: opcode_w];
		if ((op == op_special && w != '0 && fn != fn_jr) || op == op_sw || op == op_beq) begin
			return int'(w[rt_lsb +: field_w]);
		end
		return 0;
	endfunction

	function automatic int imm_operand(input logic [`PIPE_XLEN-1:0] w);
		logic [opcode_w-1:0] op;
		op = w[op_lsb +: opcode_w];
		return (op == op_ori || op == op_lui || op == op_lw || op == op_sw) ? 1 : 0;
	endfunction

	function automatic int alu_op_for(input logic [`PIPE_XLEN-1:0] w);
		logic [opcode_w-1:0] op;
		logic [opcode_w-1:0] fn;
		op = w[op_lsb +: opcode_w];
		fn = w[funct_lsb +: opcode_w];
		if (op == op_special && w != '0 && fn == fn_addu) begin
			return int'(alu_add);
		end else if (op == op_special && w != '0 && fn == fn_subu) begin
			return int'(alu_sub);
		end else if (op == op_special && w != '0 && fn == fn_movz) begin
			return int'(alu_movz);
		end else if (op == op_lw || op == op_sw) begin
			return int'(alu_add);
		end
		return int'(alu_or);
	endfunction

	task automatic check_value(input string name, input int actual, input int exp_val,
			input int row);
		assert (actual == exp_val) else begin
			$display("FAILED time %0t ns row %0d: %s expected %0d got %0d", $time, row, name,
				exp_val, actual);
			value_errors = value_errors + 1;
		end
	endtask

	task automatic check_row(input int row);
		for (int k = 0; k < n_fields; k++) begin
			check_value(field_name(k), observed(k), expected[row * n_fields + k], row);
		end
	endtask

	// read addresses come from the D word, ALU controls from the E word
	task automatic check_operands(input int row);
		check_value("rf_read_addr1", 32'(rf_read_addr1), read_addr1(stim_instr[row]), row);
		check_value("rf_read_addr2", 32'(rf_read_addr2), read_addr2(stim_instr[row]), row);
		check_value("alu_src", 32'(alu_src), imm_operand(e_word), row);
		check_value("alu_op", 32'(alu_op), alu_op_for(e_word), row);
		// no row puts a matching source in E operand 2 or in M store data
		check_value("fwd_e2", 32'(fwd_e2), int'(fwd_orig), row);
		check_value("fwd_m", 32'(fwd_m), int'(fwd_orig), row);
	endtask

	task automatic finish_run();
		$display("run over with %0d value errors and %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// ##################################################
	// drive one row per cycle
	// ##################################################
	initial begin
		d_instr = '0;
		rf_read_data2 = '0;
		e_word = '0;
		load_stimulus();
		cycle_limit = 2 * stim_instr.size() + 20;
		wait (rst_n === 1'b1);
		for (int i = 0; i < stim_instr.size(); i++) begin
			@(posedge clk);
			#(drive_delay);
			d_instr = stim_instr[i];
			rf_read_data2 = stim_data2[i];
			// outputs are combinational, so they have settled well before the next edge
			#(clk_period - drive_delay - check_lead);
			check_row(i);
			check_operands(i);
			// a stalled row leaves a bubble in E for the next row
			e_word = (expected[i * n_fields] != 0) ? '0 : stim_instr[i];
		end
		@(posedge clk);
		finish_run();
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycle_count = cycle_count + 1;
			if (cycle_count > cycle_limit) begin
				$display("run stopped by timeout after %0d cycles", cycle_count);
				other_errors = other_errors + 1;
				finish_run();
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/pipe_control_stimulus.txt
# d_instr rf_read_data2 (hex), then stall fwd_d1 fwd_d2 fwd_e1 dm_we rf_we rf_waddr wb_sel npc ext
# one row per cycle in decimal enum codes, a stalled row is repeated on the next row
00000000 00000000 0 0 0 0 0 0 0 0 0 0
00000000 00000000 0 0 0 0 0 0 0 0 0 0
ac220004 00000000 0 0 0 0 0 0 0 0 0 0
00222021 00000000 0 0 0 0 0 0 0 0 0 0
00000000 00000000 0 0 0 0 1 0 0 0 0 0
00000000 00000000 0 0 0 0 0 0 0 0 0 0
00221821 00000000 0 0 0 0 0 1 4 1 0 0
34650010 00000000 0 0 0 0 0 0 0 0 0 1
34680001 00000000 0 3 0 6 0 0 0 0 0 1
00224821 00000000 0 0 0 8 0 1 3 1 0 0
11210004 00000000 1 0 0 0 0 1 5 1 1 0
11210004 00000000 0 3 0 0 0 1 8 1 1 0
8c250000 00000000 0 0 0 8 0 1 9 1 0 0
00a25021 00000000 1 0 0 0 0 0 0 0 0 0
00a25021 00000000 0 0 0 0 0 0 0 0 0 0
0022580a 00000000 0 0 0 8 0 1 5 2 0 0
0022600a 00000005 0 0 0 0 0 0 0 0 0 0
0c000100 00000000 0 0 0 0 0 1 10 1 2 0
08000040 00000000 0 0 0 0 0 1 11 1 2 0
03e00008 00000000 0 4 0 0 0 1 0 1 3 0
3c0d1234 00000000 0 0 0 8 0 1 31 3 0 2
00000000 00000000 0 0 0 0 0 0 0 0 0 0
00000000 00000000 0 0 0 0 0 0 0 0 0 0
00000000 00000000 0 0 0 0 0 1 13 1 0 0
00000000 00000000 0 0 0 0 0 0 0 0 0 0

//--- tb.f
+incdir+include
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_classify.sv
hdl/stage_pipe.sv
hdl/decode_ctrl.sv
hdl/forward_select.sv
hdl/hazard_detect.sv
hdl/pipe_control_top.sv
verif/tb_clock_gen.sv
verif/pipe_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
sim_bin=pipe_control_sim

verilator --binary --timing --assert -f tb.f --top-module pipe_control_tb -o "$sim_bin"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/"$sim_bin" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

# the testbench reports its verdict in the log
if grep -q "sim failed" "$log_file"; then
	echo "failure found in $log_file"
	exit 1
fi

exit 0
